// ==== vga_bus_pkg.sv ====
//////////////////////////////////////////////////
// Host bus and video RAM request types
// Video RAM is 4096 words of 16 bits, word addressed
//////////////////////////////////////////////////

package vga_bus_pkg;

  // Video RAM word address width
  localparam int VRAM_AW = 12;

  typedef logic [VRAM_AW-1:0] vram_addr_t;

  // Host access as seen on the slave port, held until ack
  typedef struct packed {
    vram_addr_t  addr;
    logic [15:0] dat;
    logic [1:0]  sel;
    logic        we;
  } host_req_t;

  // One access to video RAM
  typedef struct packed {
    vram_addr_t  addr;
    logic [15:0] dat;
    logic [1:0]  sel;
    logic        we;
  } mem_req_t;

endpackage

// ==== vga_cfg_pkg.sv ====
//////////////////////////////////////////////////
// Register map, config structs and fixed timing
// REG_MODE: bit 0 write mode, bits 2:1 raster op,
// bit 4 display enable
//////////////////////////////////////////////////

package vga_cfg_pkg;

  // Register word offsets, low address bits
  localparam int REG_AW = 3;
  localparam logic [REG_AW-1:0] REG_MODE     = 3'd0;
  localparam logic [REG_AW-1:0] REG_BITMASK  = 3'd1;
  localparam logic [REG_AW-1:0] REG_START    = 3'd2;
  localparam logic [REG_AW-1:0] REG_PAL_IDX  = 3'd3;
  localparam logic [REG_AW-1:0] REG_PAL_DATA = 3'd4;
  localparam logic [REG_AW-1:0] REG_STATUS   = 3'd5;

  typedef struct packed {
    logic        write_mode;
    logic [1:0]  raster_op;
    logic [15:0] bitmask;
  } gfx_cfg_t;

  typedef struct packed {
    logic                    display_en;
    vga_bus_pkg::vram_addr_t start_addr;
  } disp_cfg_t;

  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb_t;

  typedef struct packed {
    logic       we;
    logic [3:0] idx;
    rgb_t       color;
  } pal_wr_t;

  // Per-pixel timing flags, syncs active low
  typedef struct packed {
    logic active;
    logic hsync;
    logic vsync;
  } tim_t;

  localparam tim_t TIM_BLANK = '{active: 1'b0, hsync: 1'b1, vsync: 1'b1};

  // Tiny fixed video timing, in clocks and lines
  localparam int H_ACTIVE       = 32;
  localparam int H_SYNC_START   = 34;
  localparam int H_SYNC_END     = 38;
  localparam int H_TOTAL        = 40;
  localparam int V_ACTIVE       = 8;
  localparam int V_SYNC_START   = 9;
  localparam int V_SYNC_END     = 11;
  localparam int V_TOTAL        = 12;
  localparam int H_CNT_W        = $clog2(H_TOTAL);
  localparam int V_CNT_W        = $clog2(V_TOTAL);
  localparam int WORDS_PER_LINE = 8;
  localparam int PIX_PER_WORD   = 4;
  localparam int PIX_LATENCY    = 3;

endpackage

// ==== vga_config_regs.sv ====
//////////////////////////////////////////////////
// Configuration registers, ack one cycle after stb
// Palette data writes auto-increment the index
//////////////////////////////////////////////////

`timescale 1ns/1ps

module vga_config_regs (
  input  logic                   wb_clk_i,
  input  logic                   rst_n_i,
  input  vga_bus_pkg::host_req_t req_i,
  input  logic                   stb_i,
  output logic [15:0]            dat_o,
  output logic                   ack_o,
  input  logic                   v_retrace_i,
  output vga_cfg_pkg::gfx_cfg_t  gfx_cfg_o,
  output vga_cfg_pkg::disp_cfg_t disp_cfg_o,
  output vga_cfg_pkg::pal_wr_t   pal_wr_o
);

  logic                           ack_q;
  logic [15:0]                    dat_q;
  logic                           start;
  logic [vga_cfg_pkg::REG_AW-1:0] reg_sel;
  logic [3:0]                     pal_idx_q;
  vga_cfg_pkg::gfx_cfg_t          gfx_q;
  vga_cfg_pkg::disp_cfg_t         disp_q;
  vga_cfg_pkg::pal_wr_t           pal_wr_q;

  // First cycle of a strobe
  assign start   = stb_i & ~ack_q;
  assign reg_sel = req_i.addr[vga_cfg_pkg::REG_AW-1:0];

  always_ff @(posedge wb_clk_i) begin
    if (!rst_n_i) begin
      ack_q     <= 1'b0;
      gfx_q     <= '0;
      disp_q    <= '0;
      pal_idx_q <= '0;
      pal_wr_q  <= '0;
    end else begin
      ack_q       <= start;
      pal_wr_q.we <= 1'b0;
      if (start && req_i.we) begin
        case (reg_sel)
          vga_cfg_pkg::REG_MODE: if (req_i.sel[0]) begin
            gfx_q.write_mode  <= req_i.dat[0];
            gfx_q.raster_op   <= req_i.dat[2:1];
            disp_q.display_en <= req_i.dat[4];
          end
          vga_cfg_pkg::REG_BITMASK: begin
            if (req_i.sel[0]) gfx_q.bitmask[7:0] <= req_i.dat[7:0];
            if (req_i.sel[1]) gfx_q.bitmask[15:8] <= req_i.dat[15:8];
          end
          vga_cfg_pkg::REG_START: begin
            if (req_i.sel[0]) disp_q.start_addr[7:0] <= req_i.dat[7:0];
            if (req_i.sel[1]) disp_q.start_addr[11:8] <= req_i.dat[11:8];
          end
          vga_cfg_pkg::REG_PAL_IDX: if (req_i.sel[0]) pal_idx_q <= req_i.dat[3:0];
          vga_cfg_pkg::REG_PAL_DATA: begin
            pal_wr_q  <= '{we: 1'b1, idx: pal_idx_q, color: req_i.dat[11:0]};
            pal_idx_q <= pal_idx_q + 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

  // Read data sampled on the first strobe cycle
  always_ff @(posedge wb_clk_i) begin
    if (start) begin
      case (reg_sel)
        vga_cfg_pkg::REG_MODE:
          dat_q <= {11'b0, disp_q.display_en, 1'b0, gfx_q.raster_op, gfx_q.write_mode};
        vga_cfg_pkg::REG_BITMASK: dat_q <= gfx_q.bitmask;
        vga_cfg_pkg::REG_START:   dat_q <= {4'b0, disp_q.start_addr};
        vga_cfg_pkg::REG_PAL_IDX: dat_q <= {12'b0, pal_idx_q};
        vga_cfg_pkg::REG_STATUS:  dat_q <= {15'b0, v_retrace_i};
        default:                  dat_q <= '0;
      endcase
    end
  end

  assign dat_o      = dat_q;
  assign ack_o      = ack_q;
  assign gfx_cfg_o  = gfx_q;
  assign disp_cfg_o = disp_q;
  assign pal_wr_o   = pal_wr_q;

endmodule

// ==== vga_gfx_write.sv ====
//////////////////////////////////////////////////
// Host memory path with two write modes
// Mode 1 is read-modify-write, both bytes written
//////////////////////////////////////////////////

`timescale 1ns/1ps

module vga_gfx_write (
  input  logic                   wb_clk_i,
  input  logic                   rst_n_i,
  input  vga_bus_pkg::host_req_t req_i,
  input  logic                   stb_i,
  output logic [15:0]            dat_o,
  output logic                   ack_o,
  input  vga_cfg_pkg::gfx_cfg_t  cfg_i,
  output vga_bus_pkg::mem_req_t  mem_req_o,
  output logic                   mem_valid_o,
  input  logic                   grant_i,
  input  logic [15:0]            mem_dat_i
);

  typedef enum logic [2:0] {S_IDLE, S_READ, S_WAIT, S_WRITE, S_DONE} state_e;

  state_e                state_q;
  vga_bus_pkg::mem_req_t req_q;
  logic [15:0]           dat_q;
  logic [15:0]           rop_dat;
  logic [15:0]           merged;
  logic                  direct_wr;

  assign direct_wr = req_i.we & ~cfg_i.write_mode;

  // Raster op on host data, then keep old bits outside the mask
  always_comb begin
    case (cfg_i.raster_op)
      2'd1:    rop_dat = req_i.dat & mem_dat_i;
      2'd2:    rop_dat = req_i.dat | mem_dat_i;
      2'd3:    rop_dat = req_i.dat ^ mem_dat_i;
      default: rop_dat = req_i.dat;
    endcase
    merged = (rop_dat & cfg_i.bitmask) | (mem_dat_i & ~cfg_i.bitmask);
  end

  always_ff @(posedge wb_clk_i) begin
    if (!rst_n_i) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE:  if (stb_i) state_q <= direct_wr ? S_WRITE : S_READ;
        S_READ:  if (grant_i) state_q <= S_WAIT;
        // RAM word is on mem_dat_i here
        S_WAIT:  state_q <= req_i.we ? S_WRITE : S_DONE;
        S_WRITE: if (grant_i) state_q <= S_DONE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (state_q == S_IDLE && stb_i) begin
      req_q <= '{addr: req_i.addr, dat: req_i.dat, sel: req_i.sel, we: direct_wr};
    end
    if (state_q == S_WAIT) begin
      dat_q     <= mem_dat_i;
      req_q.dat <= merged;
      req_q.sel <= 2'b11;
      req_q.we  <= 1'b1;
    end
  end

  assign mem_req_o   = req_q;
  assign mem_valid_o = (state_q == S_READ) || (state_q == S_WRITE);
  assign ack_o       = state_q == S_DONE;
  assign dat_o       = dat_q;

endmodule

// ==== vga_mem_arbiter.sv ====
//////////////////////////////////////////////////
// Video RAM arbiter, display fetch always wins
// Host waits while a fetch is requested
//////////////////////////////////////////////////

`timescale 1ns/1ps

module vga_mem_arbiter (
  input  logic                    wb_clk_i,
  input  logic                    rst_n_i,
  input  logic                    fetch_valid_i,
  input  vga_bus_pkg::vram_addr_t fetch_addr_i,
  output logic [15:0]             fetch_dat_o,
  input  vga_bus_pkg::mem_req_t   host_req_i,
  input  logic                    host_valid_i,
  output logic                    host_grant_o,
  output logic [15:0]             host_dat_o,
  output vga_bus_pkg::mem_req_t   ram_req_o,
  output logic                    ram_en_o,
  input  logic [15:0]             ram_dat_i
);

  // High when last cycle's RAM access was a fetch
  logic owner_q;

  assign host_grant_o = host_valid_i & ~fetch_valid_i;
  assign ram_en_o     = fetch_valid_i | host_valid_i;

  always_comb begin
    if (fetch_valid_i) begin
      ram_req_o      = '0;
      ram_req_o.addr = fetch_addr_i;
    end else begin
      ram_req_o = host_req_i;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (!rst_n_i) begin
      owner_q <= 1'b0;
    end else begin
      owner_q <= fetch_valid_i;
    end
  end

  // Steer read data to whoever owned the access
  assign fetch_dat_o = owner_q ? ram_dat_i : '0;
  assign host_dat_o  = owner_q ? '0 : ram_dat_i;

endmodule

// ==== vga_video_ram.sv ====
//////////////////////////////////////////////////
// 4096 x 16 single-port RAM, registered read
// Contents are undefined until written
//////////////////////////////////////////////////

`timescale 1ns/1ps

module vga_video_ram (
  input  logic                  wb_clk_i,
  input  vga_bus_pkg::mem_req_t req_i,
  input  logic                  en_i,
  output logic [15:0]           dat_o
);

  // One array per byte lane
  logic [7:0] mem_lo [2**vga_bus_pkg::VRAM_AW];
  logic [7:0] mem_hi [2**vga_bus_pkg::VRAM_AW];

  always_ff @(posedge wb_clk_i) begin
    if (en_i) begin
      if (req_i.we && req_i.sel[0]) mem_lo[req_i.addr] <= req_i.dat[7:0];
      if (req_i.we && req_i.sel[1]) mem_hi[req_i.addr] <= req_i.dat[15:8];
      dat_o <= {mem_hi[req_i.addr], mem_lo[req_i.addr]};
    end
  end

endmodule

// ==== vga_scanout.sv ====
//////////////////////////////////////////////////
// Fixed timing scanout at 4 bits per pixel
// Colour and syncs leave PIX_LATENCY clocks late
//////////////////////////////////////////////////

`timescale 1ns/1ps

module vga_scanout (
  input  logic                    wb_clk_i,
  input  logic                    rst_n_i,
  input  vga_cfg_pkg::disp_cfg_t  cfg_i,
  input  vga_cfg_pkg::pal_wr_t    pal_wr_i,
  output logic                    fetch_valid_o,
  output vga_bus_pkg::vram_addr_t fetch_addr_o,
  input  logic [15:0]             fetch_dat_i,
  output logic                    v_retrace_o,
  output logic [3:0]              vga_red_o,
  output logic [3:0]              vga_green_o,
  output logic [3:0]              vga_blue_o,
  output logic                    vga_hsync_o,
  output logic                    vga_vsync_o
);

  logic [vga_cfg_pkg::H_CNT_W-1:0]              hcnt_q;
  logic [vga_cfg_pkg::V_CNT_W-1:0]              vcnt_q;
  logic                                         in_area;
  logic                                         fetch_pend_q;
  logic [15:0]                                  shift_q;
  vga_cfg_pkg::rgb_t                            pal_q [16];
  vga_cfg_pkg::rgb_t                            rgb_q;
  vga_cfg_pkg::tim_t                            tim_raw;
  vga_cfg_pkg::tim_t [vga_cfg_pkg::PIX_LATENCY-1:0] tim_pipe_q;

  always_ff @(posedge wb_clk_i) begin
    if (!rst_n_i) begin
      hcnt_q <= '0;
      vcnt_q <= '0;
    end else if (hcnt_q == vga_cfg_pkg::H_TOTAL - 1) begin
      hcnt_q <= '0;
      vcnt_q <= (vcnt_q == vga_cfg_pkg::V_TOTAL - 1) ? '0 : vcnt_q + 1'b1;
    end else begin
      hcnt_q <= hcnt_q + 1'b1;
    end
  end

  assign in_area = hcnt_q < vga_cfg_pkg::H_ACTIVE && vcnt_q < vga_cfg_pkg::V_ACTIVE;

  // One fetch per word, on its first column
  assign fetch_valid_o = cfg_i.display_en && in_area &&
                         (hcnt_q % vga_cfg_pkg::PIX_PER_WORD) == 0;
  assign fetch_addr_o  = cfg_i.start_addr +
                         vga_bus_pkg::vram_addr_t'(vcnt_q * vga_cfg_pkg::WORDS_PER_LINE) +
                         vga_bus_pkg::vram_addr_t'(hcnt_q / vga_cfg_pkg::PIX_PER_WORD);
  assign v_retrace_o   = vcnt_q >= vga_cfg_pkg::V_ACTIVE;

  assign tim_raw.active = cfg_i.display_en && in_area;
  assign tim_raw.hsync  = !(hcnt_q >= vga_cfg_pkg::H_SYNC_START &&
                            hcnt_q < vga_cfg_pkg::H_SYNC_END);
  assign tim_raw.vsync  = !(vcnt_q >= vga_cfg_pkg::V_SYNC_START &&
                            vcnt_q < vga_cfg_pkg::V_SYNC_END);

  always_ff @(posedge wb_clk_i) begin
    if (!rst_n_i) begin
      fetch_pend_q <= 1'b0;
      tim_pipe_q   <= {vga_cfg_pkg::PIX_LATENCY{vga_cfg_pkg::TIM_BLANK}};
      rgb_q        <= '0;
    end else begin
      fetch_pend_q <= fetch_valid_o;
      tim_pipe_q   <= {tim_pipe_q[vga_cfg_pkg::PIX_LATENCY-2:0], tim_raw};
      // Colour register is the last pipeline stage
      if (tim_pipe_q[vga_cfg_pkg::PIX_LATENCY-2].active) rgb_q <= pal_q[shift_q[3:0]];
      else rgb_q <= '0;
    end
  end

  // Word arrives a cycle after its fetch, low nibble first
  always_ff @(posedge wb_clk_i) begin
    if (fetch_pend_q) shift_q <= fetch_dat_i;
    else shift_q <= {4'b0, shift_q[15:4]};
    if (pal_wr_i.we) pal_q[pal_wr_i.idx] <= pal_wr_i.color;
  end

  assign vga_red_o   = rgb_q.r;
  assign vga_green_o = rgb_q.g;
  assign vga_blue_o  = rgb_q.b;
  assign vga_hsync_o = tim_pipe_q[vga_cfg_pkg::PIX_LATENCY-1].hsync;
  assign vga_vsync_o = tim_pipe_q[vga_cfg_pkg::PIX_LATENCY-1].vsync;

endmodule

// ==== vga.sv ====
//////////////////////////////////////////////////
// Wishbone display subsystem, tag high selects
// config registers, tag low video memory
//////////////////////////////////////////////////

`timescale 1ns/1ps

module vga (
  input  logic        wb_clk_i,
  input  logic        rst_n_i,
  input  logic [15:0] wb_dat_i,
  output logic [15:0] wb_dat_o,
  input  logic [11:0] wb_adr_i,
  input  logic        wb_we_i,
  input  logic        wb_tga_i,
  input  logic [1:0]  wb_sel_i,
  input  logic        wb_stb_i,
  input  logic        wb_cyc_i,
  output logic        wb_ack_o,
  output logic [3:0]  vga_red_o,
  output logic [3:0]  vga_green_o,
  output logic [3:0]  vga_blue_o,
  output logic        vga_hsync_o,
  output logic        vga_vsync_o
);

  logic                    stb;
  vga_bus_pkg::host_req_t  host_req;
  logic [15:0]             cfg_dat, mem_dat;
  logic                    cfg_ack, mem_ack;
  vga_cfg_pkg::gfx_cfg_t   gfx_cfg;
  vga_cfg_pkg::disp_cfg_t  disp_cfg;
  vga_cfg_pkg::pal_wr_t    pal_wr;
  logic                    v_retrace;
  vga_bus_pkg::mem_req_t   gfx_req, ram_req;
  logic                    gfx_valid, gfx_grant, ram_en;
  logic [15:0]             gfx_dat, ram_dat, fetch_dat;
  logic                    fetch_valid;
  vga_bus_pkg::vram_addr_t fetch_addr;

  assign stb      = wb_cyc_i & wb_stb_i;
  assign host_req = '{addr: wb_adr_i, dat: wb_dat_i, sel: wb_sel_i, we: wb_we_i};
  assign wb_dat_o = wb_tga_i ? cfg_dat : mem_dat;
  assign wb_ack_o = stb & (wb_tga_i ? cfg_ack : mem_ack);

  vga_config_regs config_regs0 (
    .wb_clk_i, .rst_n_i, .req_i(host_req), .stb_i(stb & wb_tga_i),
    .dat_o(cfg_dat), .ack_o(cfg_ack), .v_retrace_i(v_retrace),
    .gfx_cfg_o(gfx_cfg), .disp_cfg_o(disp_cfg), .pal_wr_o(pal_wr)
  );

  vga_gfx_write gfx_write0 (
    .wb_clk_i, .rst_n_i, .req_i(host_req), .stb_i(stb & ~wb_tga_i),
    .dat_o(mem_dat), .ack_o(mem_ack), .cfg_i(gfx_cfg),
    .mem_req_o(gfx_req), .mem_valid_o(gfx_valid), .grant_i(gfx_grant), .mem_dat_i(gfx_dat)
  );

  vga_mem_arbiter arbiter0 (
    .wb_clk_i, .rst_n_i,
    .fetch_valid_i(fetch_valid), .fetch_addr_i(fetch_addr), .fetch_dat_o(fetch_dat),
    .host_req_i(gfx_req), .host_valid_i(gfx_valid), .host_grant_o(gfx_grant),
    .host_dat_o(gfx_dat), .ram_req_o(ram_req), .ram_en_o(ram_en), .ram_dat_i(ram_dat)
  );

  vga_video_ram video_ram0 (.wb_clk_i, .req_i(ram_req), .en_i(ram_en), .dat_o(ram_dat));

  vga_scanout scanout0 (
    .wb_clk_i, .rst_n_i, .cfg_i(disp_cfg), .pal_wr_i(pal_wr),
    .fetch_valid_o(fetch_valid), .fetch_addr_o(fetch_addr), .fetch_dat_i(fetch_dat),
    .v_retrace_o(v_retrace), .vga_red_o, .vga_green_o, .vga_blue_o,
    .vga_hsync_o, .vga_vsync_o
  );

endmodule

// ==== vga_assertions.sv ====
//////////////////////////////////////////////////
// Bus and video output rules bound into vga
// Acks of both targets are checked before the tag mux
//////////////////////////////////////////////////

`timescale 1ns/1ps

module vga_assertions (
  input logic       wb_clk_i,
  input logic       rst_n_i,
  input logic       wb_cyc_i,
  input logic       wb_stb_i,
  input logic       wb_ack_o,
  input logic       cfg_ack_i,
  input logic       mem_ack_i,
  input logic [3:0] vga_red_o,
  input logic [3:0] vga_green_o,
  input logic [3:0] vga_blue_o,
  input logic       vga_hsync_o,
  input logic       vga_vsync_o
);

  // No target acks outside an active access
  ack_in_access: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    (cfg_ack_i || mem_ack_i) |-> wb_cyc_i && wb_stb_i)
    else $error("ack high outside an active access");

  // Ack is a single pulse
  ack_one_cycle: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    wb_ack_o |=> !wb_ack_o)
    else $error("ack high in two consecutive cycles");

  // Blanking covers both sync pulses
  blank_in_sync: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    (!vga_hsync_o || !vga_vsync_o) |-> {vga_red_o, vga_green_o, vga_blue_o} == '0)
    else $error("colour not zero during sync");

  idle_after_reset: assert property (@(posedge wb_clk_i)
    $rose(rst_n_i) |-> vga_hsync_o && vga_vsync_o && !wb_ack_o)
    else $error("outputs not idle after reset");

endmodule

bind vga vga_assertions assertions0 (.*, .cfg_ack_i(cfg_ack), .mem_ack_i(mem_ack));

// ==== tb_vga.sv ====
//////////////////////////////////////////////////
// Directed tests for the display subsystem
// Pixel checks need rows 0 and 3 to lie inside
// the 64 words written, with start 0 and 8
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_vga;

  localparam int SYNC_LIMIT = 2 * vga_cfg_pkg::H_TOTAL * vga_cfg_pkg::V_TOTAL;
  localparam int ACK_LIMIT  = 50;
  localparam int POLL_LIMIT = 200;

  logic        wb_clk_i;
  logic        rst_n_i;
  logic [15:0] wb_dat_i;
  logic [15:0] wb_dat_o;
  logic [11:0] wb_adr_i;
  logic        wb_we_i;
  logic        wb_tga_i;
  logic [1:0]  wb_sel_i;
  logic        wb_stb_i;
  logic        wb_cyc_i;
  logic        wb_ack_o;
  logic [3:0]  vga_red_o;
  logic [3:0]  vga_green_o;
  logic [3:0]  vga_blue_o;
  logic        vga_hsync_o;
  logic        vga_vsync_o;

  logic [31:0]             rng;
  logic [15:0]             mem_model [2**vga_bus_pkg::VRAM_AW];
  vga_cfg_pkg::rgb_t       pal_model [16];
  vga_bus_pkg::vram_addr_t start_model;
  int                      err_count;
  int                      check_count;
  int                      test_count;
  int                      test_fail_count;
  int                      test_err_base;

  vga dut0 (.*);

  initial begin
    wb_clk_i = 1'b0;
    forever #10 wb_clk_i = ~wb_clk_i;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Byte lanes picked by sel come from dat
  function automatic logic [15:0] merge_bytes(input logic [15:0] old, input logic [15:0] dat,
                                              input logic [1:0] sel);
    return {sel[1] ? dat[15:8] : old[15:8], sel[0] ? dat[7:0] : old[7:0]};
  endfunction

  function automatic logic [15:0] raster(input logic [1:0] op, input logic [15:0] old,
                                         input logic [15:0] dat, input logic [15:0] mask);
    logic [15:0] res;
    case (op)
      2'd0:    res = dat;
      2'd1:    res = dat & old;
      2'd2:    res = dat | old;
      default: res = dat ^ old;
    endcase
    return (res & mask) | (old & ~mask);
  endfunction

  function automatic vga_cfg_pkg::rgb_t expected_pixel(input int c, input int r);
    int          idx;
    logic [15:0] word;
    idx  = (int'(start_model) + r * vga_cfg_pkg::WORDS_PER_LINE + c / 4) % 4096;
    word = mem_model[idx];
    return pal_model[word[4 * (c % 4) +: 4]];
  endfunction

  task automatic check_word(input string what, input logic [15:0] got,
                            input logic [15:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_rgb(input string what, input vga_cfg_pkg::rgb_t got,
                           input vga_cfg_pkg::rgb_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Mismatch at %0t: %s is rgb %h/%h/%h, expected %h/%h/%h", $time, what,
               got.r, got.g, got.b, exp.r, exp.g, exp.b);
    end
  endtask

  task automatic report_timeout(input string what);
    err_count++;
    $display("Timed out at %0t while waiting for %s", $time, what);
  endtask

  // One bus access, inputs change 2 ns after the clock edge
  task automatic wb_access(input logic tag, input logic we, input logic [11:0] adr,
                           input logic [15:0] dat, input logic [1:0] sel,
                           output logic [15:0] rdat);
    int n;
    @(posedge wb_clk_i);
    #2;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_tga_i = tag;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_sel_i = sel;
    n = 0;
    do begin
      @(posedge wb_clk_i);
      #1;
      n++;
    end while (!wb_ack_o && n < ACK_LIMIT);
    if (!wb_ack_o) report_timeout("bus ack");
    rdat = wb_dat_o;
    @(posedge wb_clk_i);
    #2;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input logic tag, input logic [11:0] adr, input logic [15:0] dat,
                          input logic [1:0] sel);
    logic [15:0] unused;
    wb_access(tag, 1'b1, adr, dat, sel, unused);
  endtask

  task automatic wb_read(input logic tag, input logic [11:0] adr, output logic [15:0] rdat);
    wb_access(tag, 1'b0, adr, 16'h0000, 2'b11, rdat);
  endtask

  // Returns just after the output edge of hsync or vsync
  task automatic wait_sync(input bit vsync, input bit rising);
    logic prev;
    logic cur;
    int   n;
    prev = vsync ? vga_vsync_o : vga_hsync_o;
    for (n = 0; n < SYNC_LIMIT; n++) begin
      @(posedge wb_clk_i);
      #1;
      cur = vsync ? vga_vsync_o : vga_hsync_o;
      if (prev !== cur && cur === rising) return;
      prev = cur;
    end
    report_timeout(vsync ? "a vsync edge" : "an hsync edge");
  endtask

  // Pixel c lands H_TOTAL - H_SYNC_END + c clocks after the hsync rise
  task automatic check_line(input int r);
    int c;
    wait_sync(1'b0, 1'b1);
    repeat (vga_cfg_pkg::H_TOTAL - vga_cfg_pkg::H_SYNC_END - 1) @(posedge wb_clk_i);
    for (c = 0; c < vga_cfg_pkg::H_ACTIVE; c++) begin
      @(posedge wb_clk_i);
      #1;
      check_rgb($sformatf("pixel %0d,%0d", c, r), {vga_red_o, vga_green_o, vga_blue_o},
                expected_pixel(c, r));
    end
  endtask

  task automatic begin_test();
    test_err_base = err_count;
  endtask

  task automatic end_test(input string name);
    test_count++;
    if (err_count != test_err_base) begin
      test_fail_count++;
      $display("%s: %0d errors", name, err_count - test_err_base);
    end else begin
      $display("%s: passed", name);
    end
  endtask

  task automatic test_reset();
    int i;
    begin_test();
    for (i = 0; i < vga_cfg_pkg::H_TOTAL * vga_cfg_pkg::V_TOTAL; i++) begin
      @(posedge wb_clk_i);
      #1;
      check_rgb("blank colour", {vga_red_o, vga_green_o, vga_blue_o}, '0);
      check_word("idle ack", {15'b0, wb_ack_o}, 16'h0000);
    end
    end_test("reset state");
  endtask

  task automatic test_config();
    logic [15:0] got;
    logic [15:0] bm;
    logic [15:0] st;
    begin_test();
    wb_write(1'b1, vga_cfg_pkg::REG_MODE, 16'h0007, 2'b11);
    wb_read(1'b1, vga_cfg_pkg::REG_MODE, got);
    check_word("mode register", got, 16'h0007);
    bm = 16'ha5c3;
    wb_write(1'b1, vga_cfg_pkg::REG_BITMASK, bm, 2'b11);
    wb_read(1'b1, vga_cfg_pkg::REG_BITMASK, got);
    check_word("bitmask register", got, bm);
    wb_write(1'b1, vga_cfg_pkg::REG_BITMASK, 16'h1234, 2'b01);
    bm = merge_bytes(bm, 16'h1234, 2'b01);
    wb_read(1'b1, vga_cfg_pkg::REG_BITMASK, got);
    check_word("bitmask low byte", got, bm);
    wb_write(1'b1, vga_cfg_pkg::REG_BITMASK, 16'h5678, 2'b10);
    bm = merge_bytes(bm, 16'h5678, 2'b10);
    wb_read(1'b1, vga_cfg_pkg::REG_BITMASK, got);
    check_word("bitmask high byte", got, bm);
    st = 16'h0abc;
    wb_write(1'b1, vga_cfg_pkg::REG_START, st, 2'b11);
    wb_read(1'b1, vga_cfg_pkg::REG_START, got);
    check_word("start register", got, st);
    // Start address is 12 bits wide
    wb_write(1'b1, vga_cfg_pkg::REG_START, 16'hf321, 2'b10);
    st = merge_bytes(st, 16'hf321, 2'b10) & 16'h0fff;
    wb_read(1'b1, vga_cfg_pkg::REG_START, got);
    check_word("start high byte", got, st);
    wb_write(1'b1, vga_cfg_pkg::REG_MODE, 16'h0000, 2'b11);
    wb_write(1'b1, vga_cfg_pkg::REG_START, 16'h0000, 2'b11);
    end_test("config readback");
  endtask

  task automatic test_mem_mode0();
    logic [11:0] adr [8];
    logic [11:0] a;
    logic [15:0] got;
    int          i;
    begin_test();
    for (i = 0; i < 8; i++) begin
      rng = xorshift(rng);
      adr[i] = {4'h1, rng[7:0]};
      mem_model[adr[i]] = rng[31:16];
      wb_write(1'b0, adr[i], rng[31:16], 2'b11);
    end
    for (i = 0; i < 8; i++) begin
      wb_read(1'b0, adr[i], got);
      check_word($sformatf("word at %h", adr[i]), got, mem_model[adr[i]]);
    end
    a = 12'h280;
    rng = xorshift(rng);
    mem_model[a] = rng[15:0];
    wb_write(1'b0, a, rng[15:0], 2'b11);
    mem_model[a] = merge_bytes(mem_model[a], rng[31:16], 2'b10);
    wb_write(1'b0, a, rng[31:16], 2'b10);
    wb_read(1'b0, a, got);
    check_word("single byte write", got, mem_model[a]);
    end_test("mode 0 memory");
  endtask

  task automatic test_raster_ops();
    logic [11:0] a;
    logic [15:0] old;
    logic [15:0] mask;
    logic [15:0] dat;
    logic [15:0] got;
    int          op;
    begin_test();
    for (op = 0; op < 4; op++) begin
      a = 12'h300 + 12'(op);
      rng = xorshift(rng);
      old = rng[15:0];
      mask = rng[31:16];
      wb_write(1'b0, a, old, 2'b11);
      wb_write(1'b1, vga_cfg_pkg::REG_BITMASK, mask, 2'b11);
      wb_write(1'b1, vga_cfg_pkg::REG_MODE, {13'b0, op[1:0], 1'b1}, 2'b01);
      rng = xorshift(rng);
      dat = rng[15:0];
      // Mode 1 writes both bytes whatever sel says
      wb_write(1'b0, a, dat, 2'b01);
      wb_write(1'b1, vga_cfg_pkg::REG_MODE, 16'h0000, 2'b01);
      mem_model[a] = raster(op[1:0], old, dat, mask);
      wb_read(1'b0, a, got);
      check_word($sformatf("raster op %0d", op), got, mem_model[a]);
    end
    end_test("mode 1 raster ops");
  endtask

  task automatic test_scanout();
    int i;
    begin_test();
    wb_write(1'b1, vga_cfg_pkg::REG_PAL_IDX, 16'h0000, 2'b01);
    for (i = 0; i < 16; i++) begin
      rng = xorshift(rng);
      pal_model[i] = rng[11:0];
      wb_write(1'b1, vga_cfg_pkg::REG_PAL_DATA, {4'b0, rng[11:0]}, 2'b11);
    end
    for (i = 0; i < 64; i++) begin
      rng = xorshift(rng);
      mem_model[i] = rng[15:0];
      wb_write(1'b0, 12'(i), rng[15:0], 2'b11);
    end
    start_model = '0;
    wb_write(1'b1, vga_cfg_pkg::REG_MODE, 16'h0010, 2'b01);
    wait_sync(1'b1, 1'b1);
    check_line(0);
    wait_sync(1'b0, 1'b1);
    wait_sync(1'b0, 1'b1);
    check_line(3);
    // Scroll down one line, seen from the next frame on
    start_model = 12'd8;
    wb_write(1'b1, vga_cfg_pkg::REG_START, 16'd8, 2'b11);
    wait_sync(1'b1, 1'b1);
    check_line(0);
    wait_sync(1'b0, 1'b1);
    wait_sync(1'b0, 1'b1);
    check_line(3);
    end_test("scanout");
  endtask

  task automatic test_retrace();
    logic [15:0] got;
    int          n;
    begin_test();
    wait_sync(1'b1, 1'b0);
    n = 0;
    do begin
      wb_read(1'b1, vga_cfg_pkg::REG_STATUS, got);
      n++;
    end while (got[0] !== 1'b1 && n < POLL_LIMIT);
    if (got[0] !== 1'b1) report_timeout("retrace status to go high");
    n = 0;
    do begin
      wb_read(1'b1, vga_cfg_pkg::REG_STATUS, got);
      n++;
    end while (got[0] !== 1'b0 && n < POLL_LIMIT);
    if (got[0] !== 1'b0) report_timeout("retrace status to go low");
    end_test("retrace status");
  endtask

  initial begin
    rst_n_i         = 1'b0;
    wb_dat_i        = '0;
    wb_adr_i        = '0;
    wb_we_i         = 1'b0;
    wb_tga_i        = 1'b0;
    wb_sel_i        = '0;
    wb_stb_i        = 1'b0;
    wb_cyc_i        = 1'b0;
    rng             = 32'hb73dd169;
    start_model     = '0;
    err_count       = 0;
    check_count     = 0;
    test_count      = 0;
    test_fail_count = 0;
    repeat (4) @(posedge wb_clk_i);
    #2;
    rst_n_i = 1'b1;
    test_reset();
    test_config();
    test_mem_mode0();
    test_raster_ops();
    test_scanout();
    test_retrace();
    $display("%0d tests, %0d failed, %0d checks, %0d errors", test_count, test_fail_count,
             check_count, err_count);
    if (err_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== vga.f ====
vga_bus_pkg.sv
vga_cfg_pkg.sv
vga_config_regs.sv
vga_gfx_write.sv
vga_mem_arbiter.sv
vga_video_ram.sv
vga_scanout.sv
vga.sv
vga_assertions.sv
tb_vga.sv

// ==== Bender.yml ====
package:
  name: vga

sources:
  - vga_bus_pkg.sv
  - vga_cfg_pkg.sv
  - vga_config_regs.sv
  - vga_gfx_write.sv
  - vga_mem_arbiter.sv
  - vga_video_ram.sv
  - vga_scanout.sv
  - vga.sv
  - target: test
    files:
      - vga_assertions.sv
      - tb_vga.sv
